// ==== Bender.yml ====
package:
  name: risc_core

sources:
  - common/risc_pkg.sv
  - hdl/risc_alu.sv
  - core/risc_regfile.sv
  - core/risc_decode.sv
  - core/risc_fetch.sv
  - core/risc_core.sv
  - target: test
    files:
      - tests/risc_tb.sv

export_include_dirs: []

frozen: false

// ==== common/risc_pkg.sv ====
// RISC core shared definitions
`default_nettype none

package risc_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int word_w     = 32;
  localparam int pc_w       = 30;  // word address
  localparam int reg_addr_w = 5;
  localparam int pcsel_w    = 3;
  localparam int sel_w      = 2;   // most select groups
  localparam int br_w       = 3;

  //////////////////////////////////////////////////
  // next pc source
  localparam logic [pcsel_w-1:0] pc_inc       = 3'd0;
  localparam logic [pcsel_w-1:0] pc_br        = 3'd1;
  localparam logic [pcsel_w-1:0] pc_jump      = 3'd2;
  localparam logic [pcsel_w-1:0] pc_jr        = 3'd3;
  localparam logic [pcsel_w-1:0] pc_reset     = 3'd4;
  localparam logic [pcsel_w-1:0] pc_exception = 3'd5;

  // operand sources
  localparam logic [sel_w-1:0] a_rs     = 2'd0;
  localparam logic [sel_w-1:0] a_16     = 2'd1;  // constant 16, for lui
  localparam logic [sel_w-1:0] a_shamt  = 2'd2;
  localparam logic [sel_w-1:0] b_rt     = 2'd0;
  localparam logic [sel_w-1:0] b_imm    = 2'd1;  // zero extended
  localparam logic [sel_w-1:0] b_sxtimm = 2'd2;

  // alu unit, boolean and shift functions
  localparam logic [sel_w-1:0] unit_addsub  = 2'd0;
  localparam logic [sel_w-1:0] unit_slt     = 2'd1;
  localparam logic [sel_w-1:0] unit_boolean = 2'd2;
  localparam logic [sel_w-1:0] unit_shifter = 2'd3;
  localparam logic [sel_w-1:0] boole_and    = 2'd0;
  localparam logic [sel_w-1:0] boole_or     = 2'd1;
  localparam logic [sel_w-1:0] boole_xor    = 2'd2;
  localparam logic [sel_w-1:0] boole_nor    = 2'd3;
  localparam logic [sel_w-1:0] shift_ll     = 2'd0;
  localparam logic [sel_w-1:0] shift_lr     = 2'd2;
  localparam logic [sel_w-1:0] shift_ar     = 2'd3;

  // write back address and data
  localparam logic [sel_w-1:0] wa_rt    = 2'd0;
  localparam logic [sel_w-1:0] wa_rd    = 2'd1;
  localparam logic [sel_w-1:0] wa_31    = 2'd2;
  localparam logic [sel_w-1:0] wa_0     = 2'd3;
  localparam logic [sel_w-1:0] wb_alu   = 2'd0;
  localparam logic [sel_w-1:0] wb_pcinc = 2'd1;
  localparam logic [sel_w-1:0] wb_mdin  = 2'd2;

  // branch condition: bit 2 inverts, bits 1:0 pick the flag
  localparam logic [br_w-1:0] br_bneq = 3'b000;
  localparam logic [br_w-1:0] br_beq  = 3'b100;
  localparam logic [br_w-1:0] br_bgtz = 3'b010;
  localparam logic [br_w-1:0] br_blez = 3'b110;
  localparam logic [br_w-1:0] br_bltz = 3'b001;
  localparam logic [br_w-1:0] br_bgez = 3'b101;

  //////////////////////////////////////////////////
  // opcodes
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_regimm  = 6'h01;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_jal     = 6'h03;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_blez    = 6'h06;
  localparam logic [5:0] op_bgtz    = 6'h07;
  localparam logic [5:0] op_addi    = 6'h08;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_sltiu   = 6'h0b;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  // special function field
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_sra  = 6'h03;
  localparam logic [5:0] fn_sllv = 6'h04;
  localparam logic [5:0] fn_srlv = 6'h06;
  localparam logic [5:0] fn_srav = 6'h07;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_jalr = 6'h09;
  localparam logic [5:0] fn_add  = 6'h20;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_sub  = 6'h22;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_nor  = 6'h27;
  localparam logic [5:0] fn_slt  = 6'h2a;
  localparam logic [5:0] fn_sltu = 6'h2b;

  // exception and reset addresses
  localparam logic [4:0]        exc_reserved = 5'd10;
  localparam logic [word_w-1:0] exc_vector   = {24'h0, exc_reserved, 3'b000};  // 0x50
  localparam logic [word_w-1:0] reset_pc     = 32'h0;

  //////////////////////////////////////////////////
  // instruction word layouts
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } inst_r_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } inst_i_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } inst_j_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_j_t j;
  } inst_u;

endpackage

`default_nettype wire

// ==== core/risc_core.sv ====
// Two-stage RISC core
`timescale 1ns/1ps
`default_nettype none

module risc_core (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        rdy,
  output logic [risc_pkg::pc_w-1:0]   iaddr,
  input  logic [risc_pkg::word_w-1:0] inst,
  output logic [risc_pkg::pc_w-1:0]   maddr,
  output logic                        mrd,
  output logic                        mwr,
  output logic [risc_pkg::word_w-1:0] mdout,
  input  logic [risc_pkg::word_w-1:0] mdin
);

  logic                              advance;
  risc_pkg::inst_u                   inst_x;
  logic [risc_pkg::pcsel_w-1:0]      pcsel;
  logic                              annul;
  logic [risc_pkg::sel_w-1:0]        asel;
  logic [risc_pkg::sel_w-1:0]        bsel;
  logic [risc_pkg::sel_w-1:0]        unit;
  logic [risc_pkg::sel_w-1:0]        boole;
  logic [risc_pkg::sel_w-1:0]        shift;
  logic                              sltu;
  logic                              sub;
  logic [risc_pkg::sel_w-1:0]        wasel;
  logic [risc_pkg::sel_w-1:0]        wbsel;
  logic [risc_pkg::word_w-1:0]       rs_data;
  logic [risc_pkg::word_w-1:0]       rt_data;
  logic [risc_pkg::word_w-1:0]       pc_inc;  // link value
  logic [risc_pkg::word_w-1:0]       a;
  logic [risc_pkg::word_w-1:0]       b;
  logic [risc_pkg::word_w-1:0]       result;
  logic [risc_pkg::word_w-1:0]       sum;
  logic [risc_pkg::reg_addr_w-1:0]   wa;
  logic [risc_pkg::word_w-1:0]       wdata;

  assign advance = rdy;  // no internal stall sources

  //////////////////////////////////////////////////
  // operand and write back muxes
  assign a = (asel == risc_pkg::a_rs)    ? rs_data :
             (asel == risc_pkg::a_shamt) ? {27'd0, inst_x.r.shamt} :
                                           32'd16;
  assign b = (bsel == risc_pkg::b_rt)  ? rt_data :
             (bsel == risc_pkg::b_imm) ? {16'd0, inst_x.i.imm} :
                                         {{16{inst_x.i.imm[15]}}, inst_x.i.imm};

  assign wa = (wasel == risc_pkg::wa_rt) ? inst_x.r.rt :
              (wasel == risc_pkg::wa_rd) ? inst_x.r.rd :
              (wasel == risc_pkg::wa_31) ? 5'd31 :
                                           5'd0;
  assign wdata = (wbsel == risc_pkg::wb_pcinc) ? pc_inc :
                 (wbsel == risc_pkg::wb_mdin)  ? mdin :
                                                 result;

  assign maddr = sum[31:2];  // word accesses only
  assign mdout = rt_data;

  //////////////////////////////////////////////////
  risc_fetch i_risc_fetch (
    .clk(clk), .reset(reset), .advance(advance), .pcsel(pcsel),
    .rs_data(rs_data), .inst(inst), .annul(annul), .inst_x(inst_x),
    .pc_inc(pc_inc), .iaddr(iaddr)
  );

  risc_decode i_risc_decode (
    .reset(reset), .inst_x(inst_x), .bsign(rs_data[31]), .bneq(rs_data != rt_data),
    .pcsel(pcsel), .annul(annul), .asel(asel), .bsel(bsel), .unit(unit),
    .boole(boole), .shift(shift), .sltu(sltu), .sub(sub), .wasel(wasel),
    .wbsel(wbsel), .mrd(mrd), .mwr(mwr)
  );

  risc_regfile i_risc_regfile (
    .clk(clk), .ra(inst_x.r.rs), .rb(inst_x.r.rt), .wa(wa), .we(advance),
    .wdata(wdata), .rs_data(rs_data), .rt_data(rt_data)
  );

  risc_alu i_risc_alu (
    .a(a), .b(b), .unit(unit), .boole(boole), .shift(shift), .sltu(sltu),
    .sub(sub), .result(result), .sum(sum)
  );

endmodule

`default_nettype wire

// ==== core/risc_decode.sv ====
// Instruction decode and branch decision
`timescale 1ns/1ps
`default_nettype none

module risc_decode (
  input  logic                         reset,
  input  risc_pkg::inst_u              inst_x,
  input  logic                         bsign,
  input  logic                         bneq,
  output logic [risc_pkg::pcsel_w-1:0] pcsel,
  output logic                         annul,
  output logic [risc_pkg::sel_w-1:0]   asel,
  output logic [risc_pkg::sel_w-1:0]   bsel,
  output logic [risc_pkg::sel_w-1:0]   unit,
  output logic [risc_pkg::sel_w-1:0]   boole,
  output logic [risc_pkg::sel_w-1:0]   shift,
  output logic                         sltu,
  output logic                         sub,
  output logic [risc_pkg::sel_w-1:0]   wasel,
  output logic [risc_pkg::sel_w-1:0]   wbsel,
  output logic                         mrd,
  output logic                         mwr
);

  logic [risc_pkg::pcsel_w-1:0] d_pcsel;
  logic [risc_pkg::sel_w-1:0]   d_wasel;
  logic [risc_pkg::br_w-1:0]    br;
  logic                         reserved;
  logic                         taken;

  always_comb
  begin
    d_pcsel  = risc_pkg::pc_inc;
    br       = risc_pkg::br_bneq;
    asel     = risc_pkg::a_rs;
    bsel     = risc_pkg::b_sxtimm;  // most immediates are signed
    unit     = risc_pkg::unit_addsub;
    boole    = risc_pkg::boole_and;
    shift    = risc_pkg::shift_ll;
    sltu     = 1'b0;
    sub      = 1'b0;
    d_wasel  = risc_pkg::wa_rt;
    wbsel    = risc_pkg::wb_alu;
    mrd      = 1'b0;
    mwr      = 1'b0;
    reserved = 1'b0;

    case (inst_x.r.op)
      risc_pkg::op_special:
      begin
        bsel    = risc_pkg::b_rt;
        d_wasel = risc_pkg::wa_rd;
        case (inst_x.r.funct)
          risc_pkg::fn_sll, risc_pkg::fn_srl, risc_pkg::fn_sra,
          risc_pkg::fn_sllv, risc_pkg::fn_srlv, risc_pkg::fn_srav:
          begin
            asel  = inst_x.r.funct[2] ? risc_pkg::a_rs : risc_pkg::a_shamt;
            unit  = risc_pkg::unit_shifter;
            shift = !inst_x.r.funct[1] ? risc_pkg::shift_ll :
                    inst_x.r.funct[0]  ? risc_pkg::shift_ar : risc_pkg::shift_lr;
          end
          risc_pkg::fn_jr:
          begin
            d_pcsel = risc_pkg::pc_jr;
            d_wasel = risc_pkg::wa_0;
          end
          risc_pkg::fn_jalr:
          begin
            d_pcsel = risc_pkg::pc_jr;
            wbsel   = risc_pkg::wb_pcinc;
          end
          risc_pkg::fn_add, risc_pkg::fn_addu:
            sub = 1'b0;                                 // no overflow traps
          risc_pkg::fn_sub, risc_pkg::fn_subu:
            sub = 1'b1;
          risc_pkg::fn_and, risc_pkg::fn_or, risc_pkg::fn_xor, risc_pkg::fn_nor:
          begin
            unit  = risc_pkg::unit_boolean;
            boole = inst_x.r.funct[1:0];                // funct order matches boole codes
          end
          risc_pkg::fn_slt, risc_pkg::fn_sltu:
          begin
            unit = risc_pkg::unit_slt;
            sub  = 1'b1;
            sltu = inst_x.r.funct[0];
          end
          default:
            reserved = 1'b1;
        endcase
      end
      risc_pkg::op_regimm:
      begin
        if (inst_x.i.rt[3:1] == 3'b000)
        begin
          d_pcsel = risc_pkg::pc_br;
          br      = inst_x.i.rt[0] ? risc_pkg::br_bgez : risc_pkg::br_bltz;
          d_wasel = inst_x.i.rt[4] ? risc_pkg::wa_31 : risc_pkg::wa_0;  // linking forms
          wbsel   = risc_pkg::wb_pcinc;
        end
        else
          reserved = 1'b1;
      end
      risc_pkg::op_j, risc_pkg::op_jal:
      begin
        d_pcsel = risc_pkg::pc_jump;
        d_wasel = inst_x.r.op[0] ? risc_pkg::wa_31 : risc_pkg::wa_0;
        wbsel   = risc_pkg::wb_pcinc;
      end
      risc_pkg::op_beq, risc_pkg::op_bne, risc_pkg::op_blez, risc_pkg::op_bgtz:
      begin
        d_pcsel = risc_pkg::pc_br;
        d_wasel = risc_pkg::wa_0;
        br = (inst_x.r.op == risc_pkg::op_beq)  ? risc_pkg::br_beq :
             (inst_x.r.op == risc_pkg::op_bne)  ? risc_pkg::br_bneq :
             (inst_x.r.op == risc_pkg::op_blez) ? risc_pkg::br_blez : risc_pkg::br_bgtz;
      end
      risc_pkg::op_addi, risc_pkg::op_addiu:
        sub = 1'b0;
      risc_pkg::op_slti, risc_pkg::op_sltiu:
      begin
        unit = risc_pkg::unit_slt;
        sub  = 1'b1;
        sltu = inst_x.r.op[0];
      end
      risc_pkg::op_andi, risc_pkg::op_ori, risc_pkg::op_xori:
      begin
        bsel  = risc_pkg::b_imm;
        unit  = risc_pkg::unit_boolean;
        boole = inst_x.r.op[1:0];
      end
      risc_pkg::op_lui:
      begin
        asel = risc_pkg::a_16;  // imm shifted left by 16
        bsel = risc_pkg::b_imm;
        unit = risc_pkg::unit_shifter;
      end
      risc_pkg::op_lw:
      begin
        mrd   = 1'b1;
        wbsel = risc_pkg::wb_mdin;
      end
      risc_pkg::op_sw:
      begin
        mwr     = 1'b1;
        d_wasel = risc_pkg::wa_0;
      end
      default:
        reserved = 1'b1;
    endcase

    annul = reserved;   // drop the instruction behind it
    if (reserved)
    begin
      d_pcsel = risc_pkg::pc_exception;
      d_wasel = risc_pkg::wa_0;
    end
  end

  //////////////////////////////////////////////////
  // branch decision
  always_comb
  begin
    case (br[1:0])
      2'b00:   taken = br[2] ^ bneq;
      2'b01:   taken = br[2] ^ bsign;
      2'b10:   taken = br[2] ^ (bneq & ~bsign);
      default: taken = 1'b0;
    endcase
  end

  assign pcsel = reset ? risc_pkg::pc_reset :
                 (d_pcsel == risc_pkg::pc_br && !taken) ? risc_pkg::pc_inc : d_pcsel;
  assign wasel = reset ? risc_pkg::wa_0 : d_wasel;  // nothing written in reset

endmodule

`default_nettype wire

// ==== core/risc_fetch.sv ====
// Fetch stage
`timescale 1ns/1ps
`default_nettype none

module risc_fetch (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         advance,
  input  logic [risc_pkg::pcsel_w-1:0] pcsel,
  input  logic [risc_pkg::word_w-1:0]  rs_data,
  input  logic [risc_pkg::word_w-1:0]  inst,
  input  logic                         annul,
  output risc_pkg::inst_u              inst_x,
  output logic [risc_pkg::word_w-1:0]  pc_inc,
  output logic [risc_pkg::pc_w-1:0]    iaddr
);

  logic [risc_pkg::word_w-1:0] pc_f;     // address being fetched
  logic [risc_pkg::word_w-1:0] pc_next;
  logic                        boot;     // first fetch after reset

  assign pc_inc = pc_f + 32'd4;  // delay slot address + 4

  always_comb
  begin
    case (pcsel)
      risc_pkg::pc_br:        pc_next = pc_f + {{14{inst_x.i.imm[15]}}, inst_x.i.imm, 2'b00};
      risc_pkg::pc_jump:      pc_next = {pc_inc[31:28], inst_x.j.target, 2'b00};
      risc_pkg::pc_jr:        pc_next = rs_data;
      risc_pkg::pc_reset:     pc_next = risc_pkg::reset_pc;
      risc_pkg::pc_exception: pc_next = risc_pkg::exc_vector;
      default:                pc_next = pc_inc;
    endcase
  end

  // synchronous instruction memory sees the next pc on the edge
  assign iaddr = (advance || reset) ? pc_next[31:2] : pc_f[31:2];

  //////////////////////////////////////////////////
  // pc and instruction register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc_f <= risc_pkg::reset_pc - 32'd4;  // so the first fetch lands on reset_pc
      boot <= 1'b1;
    end
    else if (advance)
    begin
      pc_f <= pc_next;
      boot <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      inst_x <= '0;
    else if (advance)
      inst_x <= (annul || boot) ? '0 : inst;  // zero is a no-op
  end

endmodule

`default_nettype wire

// ==== core/risc_regfile.sv ====
// Register file
`timescale 1ns/1ps
`default_nettype none

module risc_regfile (
  input  logic                            clk,
  input  logic [risc_pkg::reg_addr_w-1:0] ra,
  input  logic [risc_pkg::reg_addr_w-1:0] rb,
  input  logic [risc_pkg::reg_addr_w-1:0] wa,
  input  logic                            we,
  input  logic [risc_pkg::word_w-1:0]     wdata,
  output logic [risc_pkg::word_w-1:0]     rs_data,
  output logic [risc_pkg::word_w-1:0]     rt_data
);

  logic [risc_pkg::word_w-1:0] regs [32];

  // $0 reads as zero whatever the array holds
  assign rs_data = (ra == '0) ? '0 : regs[ra];
  assign rt_data = (rb == '0) ? '0 : regs[rb];

  always_ff @(posedge clk)
  begin
    if (we && wa != '0)
      regs[wa] <= wdata;
  end

endmodule

`default_nettype wire

// ==== hdl/risc_alu.sv ====
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module risc_alu (
  input  logic [risc_pkg::word_w-1:0] a,
  input  logic [risc_pkg::word_w-1:0] b,
  input  logic [risc_pkg::sel_w-1:0]  unit,
  input  logic [risc_pkg::sel_w-1:0]  boole,
  input  logic [risc_pkg::sel_w-1:0]  shift,
  input  logic                        sltu,
  input  logic                        sub,
  output logic [risc_pkg::word_w-1:0] result,
  output logic [risc_pkg::word_w-1:0] sum
);

  logic [32:0] aext;
  logic [32:0] bext;
  logic [32:0] sum_x;     // bit 32 is carry/borrow
  logic        ovf;
  logic        lt;
  logic        left;
  logic [4:0]  n;         // right rotate amount
  logic [31:0] rot;
  logic [31:0] mask;
  logic        fill;
  logic [31:0] shift_out;
  logic [31:0] bool_out;

  //////////////////////////////////////////////////
  // adder and compare
  assign aext  = {~sltu & a[31], a};
  assign bext  = {~sltu & b[31], b};
  assign sum_x = sub ? aext - bext : aext + bext;
  assign sum   = sum_x[31:0];
  assign ovf   = (a[31] == (b[31] ^ sub)) && (sum_x[31] != a[31]);
  assign lt    = sltu ? sum_x[32] : sum_x[31] ^ ovf;

  //////////////////////////////////////////////////
  // barrel shifter
  assign left = (shift == risc_pkg::shift_ll);
  assign n    = left ? 5'd0 - a[4:0] : a[4:0];  // left by k is right rotate by 32-k
  assign fill = (shift == risc_pkg::shift_ar) & b[31];
  assign mask = left ? 32'hffff_ffff << a[4:0] : 32'hffff_ffff >> a[4:0];

  always_comb
  begin
    rot = b;
    for (int k = 0; k < 5; k++)
    begin
      if (n[k])
        rot = (rot >> (1 << k)) | (rot << (32 - (1 << k)));
    end
  end

  assign shift_out = (rot & mask) | (~mask & {32{fill}});

  //////////////////////////////////////////////////
  // boolean unit and result select
  always_comb
  begin
    case (boole)
      risc_pkg::boole_and: bool_out = a & b;
      risc_pkg::boole_or:  bool_out = a | b;
      risc_pkg::boole_xor: bool_out = a ^ b;
      default:             bool_out = ~(a | b);  // nor
    endcase
  end

  always_comb
  begin
    case (unit)
      risc_pkg::unit_addsub:  result = sum;
      risc_pkg::unit_slt:     result = {31'd0, lt};
      risc_pkg::unit_boolean: result = bool_out;
      default:                result = shift_out;
    endcase
  end

endmodule

`default_nettype wire

// ==== tests/risc_tb.sv ====
// Core testbench
`timescale 1ns/1ps
`default_nettype none

module risc_tb;

  localparam int cycle_limit = 4000;  // 6 runs of under 100 cycles, x4 for stalls, plus margin

  logic        clk = 1'b0;
  logic        reset;
  logic        rdy;
  logic [29:0] iaddr;
  logic [31:0] inst;
  logic [29:0] maddr;
  logic        mrd;
  logic        mwr;
  logic [31:0] mdout;
  logic [31:0] mdin;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] st_addr [$];    // stores seen on the bus
  logic [31:0] st_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [29:0] fetch_log [$];  // iaddr at each advance
  logic [31:0] res [32];       // expected result registers
  logic [31:0] rng = 32'd38161;
  logic [29:0] ia;
  int          pos;
  int          n_delay;
  int          n_fall;
  int          cycles = 0;
  bit          stall_on = 1'b0;

  risc_core i_risc_core (
    .clk(clk), .reset(reset), .rdy(rdy), .iaddr(iaddr), .inst(inst), .maddr(maddr),
    .mrd(mrd), .mwr(mwr), .mdout(mdout), .mdin(mdin)
  );

  always #2 clk = ~clk;

  assign mdin = mrd ? dmem[maddr[7:0]] : 'x;  // combinational read while mrd is high

  //////////////////////////////////////////////////
  // memory models and stall source
  always @(posedge clk)
  begin
    ia = iaddr;
    if (!reset && rdy)
    begin
      fetch_log.push_back(iaddr);
      if (mwr)
      begin
        dmem[maddr[7:0]] = mdout;
        st_addr.push_back({maddr, 2'b00});
        st_data.push_back(mdout);
      end
    end
    #1;
    inst = imem[ia[7:0]];  // synchronous instruction memory
    rng = xorshift(rng);
    rdy = stall_on ? (rng[1:0] != 2'b00) : 1'b1;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: the program did not finish its stores in time");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  //////////////////////////////////////////////////
  // instruction assembler
  function automatic logic [31:0] r_inst(input logic [5:0] funct,
                                         input logic [4:0] rs, rt, rd, shamt);
    risc_pkg::inst_u w;
    w.r.op    = risc_pkg::op_special;
    w.r.rs    = rs;
    w.r.rt    = rt;
    w.r.rd    = rd;
    w.r.shamt = shamt;
    w.r.funct = funct;
    return w;
  endfunction

  function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
    risc_pkg::inst_u w;
    w.i.op  = op;
    w.i.rs  = rs;
    w.i.rt  = rt;
    w.i.imm = imm;
    return w;
  endfunction

  function automatic logic [31:0] j_inst(input logic [5:0] op, input logic [25:0] target);
    risc_pkg::inst_u w;
    w.j.op     = op;
    w.j.target = target;
    return w;
  endfunction

  function automatic logic [31:0] sxt(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic put(input logic [31:0] w);
    imem[pos] = w;
    pos++;
  endtask

  task automatic load_const(input logic [4:0] r, input logic [31:0] v);
    put(i_inst(risc_pkg::op_lui, 0, r, v[31:16]));
    put(i_inst(risc_pkg::op_ori, r, r, v[15:0]));
  endtask

  task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // store $1..$n to 0x100 upward, then park in a self-loop
  task automatic finish_prog(input int n);
    for (int k = 1; k <= n; k++)
    begin
      put(i_inst(risc_pkg::op_sw, 0, k, 16'h100 + 4 * k - 4));
      expect_store(32'h100 + 4 * k - 4, res[k]);
    end
    put(j_inst(risc_pkg::op_j, pos));
    put('0);
  endtask

  //////////////////////////////////////////////////
  // run control and checks
  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_idle_outputs(input string name);
    compare({name, " reset iaddr"}, 32'd0, iaddr);
    compare({name, " reset mrd"}, 32'd0, mrd);
    compare({name, " reset mwr"}, 32'd0, mwr);
  endtask

  task automatic start_program;
    @(posedge clk);
    #1;
    reset = 1'b1;
    stall_on = 1'b0;
    for (int k = 0; k < 256; k++)
    begin
      imem[k] = '0;
      dmem[k] = '0;
    end
    foreach (res[k])
      res[k] = '0;
    st_addr.delete();
    st_data.delete();
    exp_addr.delete();
    exp_data.delete();
    fetch_log.delete();
    pos = 0;
  endtask

  task automatic run_program(input string name, input bit stall);
    for (int k = 0; k < 7; k++)
    begin
      @(posedge clk);
      #2;
      check_idle_outputs(name);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    #1;
    check_idle_outputs(name);  // first cycle out of reset
    stall_on = stall;
    while (st_data.size() < exp_data.size())
      @(posedge clk);
    repeat (10) @(posedge clk);  // room for a stray store
    compare({name, " store count"}, exp_data.size(), st_data.size());
    foreach (exp_data[k])
    begin
      compare({name, " store address"}, exp_addr[k], st_addr[k]);
      compare({name, " store data"}, exp_data[k], st_data[k]);
    end
    stall_on = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic alu_test;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = 32'h8000_0000;
    b = 32'h7fff_ffff;
    c = 32'hffff_fff0;
    start_program();
    load_const(20, a);
    load_const(21, b);
    load_const(22, c);
    put(r_inst(risc_pkg::fn_add, 20, 21, 1, 0));
    put(r_inst(risc_pkg::fn_subu, 21, 20, 2, 0));
    put(r_inst(risc_pkg::fn_and, 21, 22, 3, 0));
    put(r_inst(risc_pkg::fn_or, 20, 22, 4, 0));
    put(r_inst(risc_pkg::fn_xor, 21, 22, 5, 0));
    put(r_inst(risc_pkg::fn_nor, 20, 21, 6, 0));
    put(r_inst(risc_pkg::fn_slt, 20, 21, 7, 0));
    put(r_inst(risc_pkg::fn_sltu, 20, 21, 8, 0));
    put(i_inst(risc_pkg::op_addi, 22, 9, 16'hfffb));
    put(i_inst(risc_pkg::op_andi, 22, 10, 16'h8f0f));
    put(i_inst(risc_pkg::op_slti, 22, 11, 16'hffff));
    put(i_inst(risc_pkg::op_sltiu, 21, 12, 16'hffff));
    put(i_inst(risc_pkg::op_lui, 0, 13, 16'hbeef));
    put(i_inst(risc_pkg::op_xori, 20, 14, 16'ha5a5));
    put(i_inst(risc_pkg::op_addiu, 0, 0, 16'd7));  // $0 must stay zero
    put(r_inst(risc_pkg::fn_add, 20, 21, 0, 0));
    put(r_inst(risc_pkg::fn_or, 0, 0, 15, 0));
    res[1]  = a + b;
    res[2]  = b - a;
    res[3]  = b & c;
    res[4]  = a | c;
    res[5]  = b ^ c;
    res[6]  = ~(a | b);
    res[7]  = {31'd0, $signed(a) < $signed(b)};
    res[8]  = {31'd0, a < b};
    res[9]  = c + sxt(16'hfffb);
    res[10] = c & 32'h0000_8f0f;
    res[11] = {31'd0, $signed(c) < $signed(sxt(16'hffff))};
    res[12] = {31'd0, b < sxt(16'hffff)};
    res[13] = 32'hbeef_0000;
    res[14] = a ^ 32'h0000_a5a5;
    res[15] = 32'd0;
    finish_prog(15);
    run_program("alu", 1'b0);
  endtask

  task automatic shift_test;
    logic [31:0] x;
    logic [31:0] amt;
    x = 32'h8765_4321;
    amt = 32'h24;  // only the low five bits count
    start_program();
    load_const(20, x);
    put(i_inst(risc_pkg::op_ori, 0, 21, 16'd31));
    put(i_inst(risc_pkg::op_ori, 0, 23, amt[15:0]));
    put(i_inst(risc_pkg::op_lui, 0, 22, 16'h4000));
    put(r_inst(risc_pkg::fn_sll, 0, 20, 1, 4));
    put(r_inst(risc_pkg::fn_srl, 0, 20, 2, 4));
    put(r_inst(risc_pkg::fn_sra, 0, 20, 3, 4));
    put(r_inst(risc_pkg::fn_sll, 0, 20, 4, 0));
    put(r_inst(risc_pkg::fn_sra, 0, 20, 5, 31));
    put(r_inst(risc_pkg::fn_srl, 0, 20, 6, 31));
    put(r_inst(risc_pkg::fn_sllv, 21, 20, 7, 0));
    put(r_inst(risc_pkg::fn_srlv, 23, 20, 8, 0));
    put(r_inst(risc_pkg::fn_srav, 23, 20, 9, 0));
    put(r_inst(risc_pkg::fn_srav, 0, 20, 10, 0));
    put(r_inst(risc_pkg::fn_srav, 21, 22, 11, 0));
    res[1]  = x << 4;
    res[2]  = x >> 4;
    res[3]  = $signed(x) >>> 4;
    res[4]  = x;
    res[5]  = $signed(x) >>> 31;
    res[6]  = x >> 31;
    res[7]  = x << 31;
    res[8]  = x >> amt[4:0];
    res[9]  = $signed(x) >>> amt[4:0];
    res[10] = x;
    res[11] = $signed(32'h4000_0000) >>> 31;  // zero fill for a positive word
    finish_prog(11);
    run_program("shift", 1'b0);
  endtask

  // branch over one instruction; delay slots count in $1, fall-throughs in $2
  task automatic branch_case(input logic [5:0] op, input logic [4:0] rs, rt, input bit taken);
    put(i_inst(op, rs, rt, 16'd2));
    put(i_inst(risc_pkg::op_addiu, 1, 1, 16'd1));
    put(i_inst(risc_pkg::op_addiu, 2, 2, 16'd1));
    n_delay++;
    if (!taken)
      n_fall++;
  endtask

  // jump over a store that must never reach the bus
  task automatic jump_case(input logic [31:0] w);
    put(w);
    put(i_inst(risc_pkg::op_addiu, 1, 1, 16'd1));
    put(i_inst(risc_pkg::op_sw, 0, 0, 16'h200));
    n_delay++;
  endtask

  task automatic control_test;
    int p;
    n_delay = 0;
    n_fall = 0;
    start_program();
    put(r_inst(risc_pkg::fn_or, 0, 0, 1, 0));
    put(r_inst(risc_pkg::fn_or, 0, 0, 2, 0));
    put(r_inst(risc_pkg::fn_or, 0, 0, 23, 0));
    put(i_inst(risc_pkg::op_ori, 0, 20, 16'd5));
    put(i_inst(risc_pkg::op_ori, 0, 21, 16'd5));
    put(i_inst(risc_pkg::op_addiu, 0, 22, 16'hfffd));  // -3
    branch_case(risc_pkg::op_beq, 20, 21, 1'b1);
    branch_case(risc_pkg::op_beq, 20, 22, 1'b0);
    branch_case(risc_pkg::op_bne, 20, 22, 1'b1);
    branch_case(risc_pkg::op_bne, 20, 21, 1'b0);
    branch_case(risc_pkg::op_blez, 22, 0, 1'b1);
    branch_case(risc_pkg::op_blez, 20, 0, 1'b0);
    branch_case(risc_pkg::op_blez, 23, 0, 1'b1);
    branch_case(risc_pkg::op_bgtz, 20, 0, 1'b1);
    branch_case(risc_pkg::op_bgtz, 23, 0, 1'b0);
    branch_case(risc_pkg::op_regimm, 22, 0, 1'b1);   // bltz
    branch_case(risc_pkg::op_regimm, 23, 0, 1'b0);
    branch_case(risc_pkg::op_regimm, 23, 1, 1'b1);   // bgez
    branch_case(risc_pkg::op_regimm, 22, 1, 1'b0);
    p = pos;
    branch_case(risc_pkg::op_regimm, 22, 16, 1'b1);  // bltzal
    res[3] = p * 4 + 8;
    put(r_inst(risc_pkg::fn_or, 31, 0, 3, 0));
    p = pos;
    branch_case(risc_pkg::op_regimm, 22, 17, 1'b0);  // bgezal links even when not taken
    res[4] = p * 4 + 8;
    put(r_inst(risc_pkg::fn_or, 31, 0, 4, 0));
    p = pos;
    jump_case(j_inst(risc_pkg::op_jal, p + 3));
    res[5] = p * 4 + 8;
    put(r_inst(risc_pkg::fn_or, 31, 0, 5, 0));
    jump_case(j_inst(risc_pkg::op_j, pos + 3));
    p = pos;
    load_const(24, (p + 5) * 4);
    jump_case(r_inst(risc_pkg::fn_jalr, 24, 0, 6, 0));
    res[6] = (p + 2) * 4 + 8;
    p = pos;
    load_const(24, (p + 5) * 4);
    jump_case(r_inst(risc_pkg::fn_jr, 24, 0, 0, 0));
    res[1] = n_delay;
    res[2] = n_fall;
    finish_prog(6);
    run_program("control", 1'b0);
  endtask

  task automatic memory_test(input bit stall);
    logic [31:0] v;
    v = 32'h1234_5678;
    start_program();
    load_const(20, v);
    put(i_inst(risc_pkg::op_sw, 0, 20, 16'h40));
    expect_store(32'h40, v);
    put(i_inst(risc_pkg::op_addiu, 0, 21, 16'h3c));
    put(i_inst(risc_pkg::op_lw, 21, 1, 16'd4));
    put(i_inst(risc_pkg::op_addiu, 1, 2, 16'd1));  // uses the load at once
    put(i_inst(risc_pkg::op_sw, 21, 2, 16'd8));
    expect_store(32'h44, v + 1);
    put(r_inst(risc_pkg::fn_addu, 1, 2, 4, 0));
    put(i_inst(risc_pkg::op_lw, 21, 3, 16'd8));
    put(i_inst(risc_pkg::op_lw, 21, 5, 16'd4));
    put(r_inst(risc_pkg::fn_subu, 3, 5, 5, 0));
    res[1] = v;
    res[2] = v + 1;
    res[3] = v + 1;
    res[4] = v + v + 1;
    res[5] = 32'd1;
    finish_prog(5);
    run_program(stall ? "memory stall" : "memory", stall);
  endtask

  task automatic reserved_test;
    int idx;
    idx = -1;
    start_program();
    put(i_inst(risc_pkg::op_addiu, 0, 1, 16'd7));
    put({6'h3f, 26'd0});                         // undefined opcode
    put(i_inst(risc_pkg::op_sw, 0, 1, 16'h300));  // annulled
    pos = 32'h50 / 4;                            // handler
    put(i_inst(risc_pkg::op_addiu, 0, 2, 16'd9));
    res[1] = 32'd7;
    res[2] = 32'd9;
    finish_prog(2);
    run_program("reserved", 1'b0);
    foreach (fetch_log[k])
    begin
      if (fetch_log[k] == 30'd1 && idx < 0)
        idx = k;
    end
    compare("reserved vector fetch", 32'h50 / 4, fetch_log[idx + 2]);
  endtask

  initial
  begin
    reset = 1'b1;
    rdy = 1'b1;
    inst = '0;
    alu_test();
    shift_test();
    control_test();
    memory_test(1'b0);
    memory_test(1'b1);
    reserved_test();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/risc_pkg.sv
hdl/risc_alu.sv
core/risc_regfile.sv
core/risc_decode.sv
core/risc_fetch.sv
core/risc_core.sv
tests/risc_tb.sv
